// ==== verilog/lenet_pkg.sv ====
`default_nettype none

package lenet_pkg;

    // ========================================================================
    // data widths
    // ========================================================================
    typedef logic [7:0]  act_t;   // activation or output pixel
    typedef logic [7:0]  wgt_t;   // kernel weight
    typedef logic [15:0] prod_t;  // one multiplier product
    typedef logic [20:0] acc_t;   // 16 bit product plus 5 bits for 25 terms
    typedef logic [4:0]  tap_t;   // position inside the 5x5 kernel

    // ========================================================================
    // window and requantization
    // ========================================================================
    localparam int N_TAPS    = 25;
    localparam int OUT_SHIFT = 8;  // sum >> 8 before clipping

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_RUN,
        ST_DRAIN
    } pe_state_t;

endpackage

`default_nettype wire

// ==== verilog/approx_mul.sv ====
`default_nettype none

module approx_mul (
    input  lenet_pkg::wgt_t  x,
    input  lenet_pkg::act_t  y,
    output lenet_pkg::prod_t z
);
    import lenet_pkg::*;

    act_t  pp [8];   // pp[i] is y gated by x[i]
    prod_t row_a;
    prod_t row_b;
    prod_t row_c;
    prod_t row_d;
    prod_t row_e;
    prod_t top_6;
    prod_t top_7;

    always_comb begin
        for (int i = 0; i < 8; i++) begin
            pp[i] = y & {8{x[i]}};
        end
    end

    // ========================================================================
    // compressed low and middle rows, bits 2..0 are dropped
    // ========================================================================
    assign row_a = {
        3'b000,
        pp[4][7] & pp[5][6],   // 12
        pp[4][6] & pp[5][5],   // 11
        pp[3][7],              // 10
        pp[2][6] & pp[3][5],   // 9
        pp[1][7],              // 8
        pp[0][7] ^ pp[1][6],   // 7
        pp[4][2] ^ pp[5][1],   // 6
        pp[0][5] | pp[1][4],   // 5
        pp[0][3] ^ pp[1][2],   // 4
        pp[0][2] ^ pp[1][1],   // 3
        3'b000
    };

    assign row_b = {
        3'b000,
        pp[5][7],              // 12
        pp[4][7] ^ pp[5][6],   // 11
        pp[4][6] ^ pp[5][5],   // 10
        pp[2][7] ^ pp[3][6],   // 9
        pp[2][5] & pp[3][4],   // 8
        pp[4][2] & pp[5][1],   // 7
        1'b0,
        pp[4][1] | pp[5][0],   // 5
        5'b00000
    };

    // sparse rows, only bits 9 and 8 carry anything
    assign row_c = {
        6'b000000,
        pp[4][4] | pp[5][3],
        pp[2][5] ^ pp[3][4],
        8'h00
    };

    assign row_d = {
        6'b000000,
        pp[4][5] & pp[5][4],
        pp[2][6] ^ pp[3][5],
        8'h00
    };

    assign row_e = {
        6'b000000,
        pp[4][5] | pp[5][4],
        pp[4][4] & pp[5][3],
        8'h00
    };

    // ========================================================================
    // exact top rows
    // ========================================================================
    assign top_6 = {2'b00, pp[6], 6'b000000};
    assign top_7 = {1'b0, pp[7], 7'b0000000};

    assign z = top_6 + top_7 + row_a + row_b + row_c + row_d + row_e;

endmodule

`default_nettype wire

// ==== verilog/tap_counter.sv ====
`default_nettype none

module tap_counter (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            take,
    input  logic            clear,
    output lenet_pkg::tap_t tap,
    output logic            last
);
    import lenet_pkg::*;

    localparam tap_t LAST_TAP = tap_t'(N_TAPS - 1);

    assign last = take && (tap == LAST_TAP);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tap <= '0;
        end else if (clear || last) begin
            tap <= '0;   // window done or restarted
        end else if (take) begin
            tap <= tap + tap_t'(1);
        end
    end

endmodule

`default_nettype wire

// ==== verilog/conv_fsm.sv ====
`default_nettype none

module conv_fsm (
    input  logic clk,
    input  logic rst_n,
    input  logic start,
    input  logic pix_valid,
    input  logic last,
    output logic take,
    output logic clear,
    output logic busy
);
    import lenet_pkg::*;

    pe_state_t state;
    pe_state_t state_nxt;
    logic      drain_cnt;  // two cycles of pipeline drain
    logic      accept;

    assign accept = start && !busy;   // busy low only in idle
    assign clear  = accept;
    assign take   = pix_valid && (state == ST_RUN);

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE:  if (accept) state_nxt = ST_RUN;
            ST_RUN:   if (last) state_nxt = ST_DRAIN;
            ST_DRAIN: if (drain_cnt) state_nxt = ST_IDLE;
            default:  state_nxt = ST_IDLE;
        endcase
    end

    // busy lags the state by one cycle so it drops together with out_valid
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= ST_IDLE;
            drain_cnt <= 1'b0;
            busy      <= 1'b0;
        end else begin
            state <= state_nxt;
            busy  <= accept || (state != ST_IDLE);
            if (state == ST_DRAIN) begin
                drain_cnt <= ~drain_cnt;
            end else begin
                drain_cnt <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/weight_store.sv ====
`default_nettype none

module weight_store (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            wt_we,
    input  lenet_pkg::tap_t wt_addr,
    input  lenet_pkg::wgt_t wt_data,
    input  logic            busy,
    input  lenet_pkg::tap_t tap,
    output lenet_pkg::wgt_t weight
);
    import lenet_pkg::*;

    wgt_t kernel [N_TAPS];
    logic wr_ok;

    assign wr_ok  = wt_we && !busy && (int'(wt_addr) < N_TAPS);
    assign weight = kernel[tap];   // tap never leaves 0..24

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < N_TAPS; i++) begin
                kernel[i] <= '0;
            end
        end else if (wr_ok) begin
            kernel[wt_addr] <= wt_data;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/mac_accum.sv ====
`default_nettype none

module mac_accum (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             take,
    input  logic             clear,
    input  logic             last,
    input  lenet_pkg::prod_t prod,
    output logic             out_valid,
    output lenet_pkg::act_t  out_data
);
    import lenet_pkg::*;

    prod_t prod_q;
    logic  prod_vld;
    logic  last_d1;    // 25th product sits in prod_q
    logic  last_d2;    // sum holds the full window
    acc_t  sum;
    acc_t  scaled;
    act_t  clipped;

    // ========================================================================
    // requantize
    // ========================================================================
    assign scaled  = sum >> OUT_SHIFT;
    assign clipped = (scaled > acc_t'(255)) ? 8'hff : scaled[7:0];

    always_ff @(posedge clk) begin
        if (take) prod_q <= prod;
        if (last_d2) out_data <= clipped;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prod_vld  <= 1'b0;
            last_d1   <= 1'b0;
            last_d2   <= 1'b0;
            sum       <= '0;
            out_valid <= 1'b0;
        end else begin
            prod_vld  <= take;
            last_d1   <= last;
            last_d2   <= last_d1;
            out_valid <= last_d2;
            if (clear || last_d2) begin
                sum <= '0;              // fresh window
            end else if (prod_vld) begin
                sum <= sum + acc_t'(prod_q);
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/conv_pe.sv ====
`default_nettype none

module conv_pe (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            wt_we,
    input  lenet_pkg::tap_t wt_addr,
    input  lenet_pkg::wgt_t wt_data,
    input  logic            start,
    input  logic            pix_valid,
    input  lenet_pkg::act_t pix_data,
    output logic            busy,
    output logic            out_valid,
    output lenet_pkg::act_t out_data
);
    import lenet_pkg::*;

    logic  take;
    logic  clear;
    logic  last;
    tap_t  tap;
    wgt_t  weight;
    prod_t prod;

    conv_fsm u_fsm (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .pix_valid (pix_valid),
        .last      (last),
        .take      (take),
        .clear     (clear),
        .busy      (busy)
    );

    tap_counter u_tap (
        .clk   (clk),
        .rst_n (rst_n),
        .take  (take),
        .clear (clear),
        .tap   (tap),
        .last  (last)
    );

    weight_store u_wgt (
        .clk     (clk),
        .rst_n   (rst_n),
        .wt_we   (wt_we),
        .wt_addr (wt_addr),
        .wt_data (wt_data),
        .busy    (busy),
        .tap     (tap),
        .weight  (weight)
    );

    // weight on x, pixel on y
    approx_mul u_mul (
        .x (weight),
        .y (pix_data),
        .z (prod)
    );

    mac_accum u_mac (
        .clk       (clk),
        .rst_n     (rst_n),
        .take      (take),
        .clear     (clear),
        .last      (last),
        .prod      (prod),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

endmodule

`default_nettype wire

// ==== tests/approx_model.svh ====
`ifndef APPROX_MODEL_SVH
`define APPROX_MODEL_SVH

// one partial product bit, weight bit i times pixel bit j
function automatic int pbit(input logic [7:0] w, input logic [7:0] a, input int i, input int j);
    return int'(w[i] & a[j]);
endfunction

// approximate 8x8 product, terms grouped by their bit weight
function automatic int approx_product(input logic [7:0] w, input logic [7:0] a);
    int s;
    s = (w[6] ? int'(a) << 6 : 0) + (w[7] ? int'(a) << 7 : 0);   // exact top rows
    s += 4096 * ((pbit(w, a, 4, 7) & pbit(w, a, 5, 6)) + pbit(w, a, 5, 7));
    s += 2048 * ((pbit(w, a, 4, 6) & pbit(w, a, 5, 5)) + (pbit(w, a, 4, 7) ^ pbit(w, a, 5, 6)));
    s += 1024 * (pbit(w, a, 3, 7) + (pbit(w, a, 4, 6) ^ pbit(w, a, 5, 5)));
    s += 512 * ((pbit(w, a, 2, 6) & pbit(w, a, 3, 5)) + (pbit(w, a, 2, 7) ^ pbit(w, a, 3, 6))
               + (pbit(w, a, 4, 4) | pbit(w, a, 5, 3)) + (pbit(w, a, 4, 5) & pbit(w, a, 5, 4))
               + (pbit(w, a, 4, 5) | pbit(w, a, 5, 4)));
    s += 256 * (pbit(w, a, 1, 7) + (pbit(w, a, 2, 5) & pbit(w, a, 3, 4))
               + (pbit(w, a, 2, 5) ^ pbit(w, a, 3, 4)) + (pbit(w, a, 2, 6) ^ pbit(w, a, 3, 5))
               + (pbit(w, a, 4, 4) & pbit(w, a, 5, 3)));
    s += 128 * ((pbit(w, a, 0, 7) ^ pbit(w, a, 1, 6)) + (pbit(w, a, 4, 2) & pbit(w, a, 5, 1)));
    s += 64 * (pbit(w, a, 4, 2) ^ pbit(w, a, 5, 1));
    s += 32 * ((pbit(w, a, 0, 5) | pbit(w, a, 1, 4)) + (pbit(w, a, 4, 1) | pbit(w, a, 5, 0)));
    s += 16 * (pbit(w, a, 0, 3) ^ pbit(w, a, 1, 2));
    s += 8 * (pbit(w, a, 0, 2) ^ pbit(w, a, 1, 1));
    return s % 65536;   // 16 bit product
endfunction

// expected output pixel of one window
function automatic logic [7:0] window_result(input logic [7:0] k [N_TAPS],
                                             input logic [7:0] p [N_TAPS]);
    int sum;
    int scaled;
    sum = 0;
    for (int i = 0; i < N_TAPS; i++) begin
        sum += approx_product(k[i], p[i]);
    end
    scaled = sum >> OUT_SHIFT;
    return (scaled > 255) ? 8'hff : scaled[7:0];
endfunction

`endif

// ==== tests/tb_conv_pe.sv ====
`default_nettype none

module tb_conv_pe;
    import lenet_pkg::*;

    `include "approx_model.svh"

    localparam int N_WIN      = 11;
    localparam int N_LOADS    = 4;
    localparam int N_IDLE     = N_TAPS + 5;   // enough to wrap the tap counter
    localparam int RST_CYC    = 8;
    localparam int WIN_CYC    = 40;
    localparam int MAX_GAPS   = 8;
    localparam int MAX_CYCLES = WIN_CYC * N_WIN + N_LOADS * (N_TAPS + 1) + RST_CYC
                                + N_IDLE + 20;

    logic   clk;
    logic   rst_n;
    logic   wt_we;
    tap_t   wt_addr;
    wgt_t   wt_data;
    logic   start;
    logic   pix_valid;
    act_t   pix_data;
    logic   busy;
    logic   out_valid;
    act_t   out_data;

    logic       pix_last;     // marks the 25th pixel of a window
    logic       seen_start;
    logic       prev_ov;
    logic [2:0] last_hist;    // last pixel flags of the past three edges
    int         cycles;
    int         fail_cnt;
    int         other_cnt;
    integer     seed;
    act_t       exp_q [$];
    wgt_t       kern [N_TAPS];
    act_t       pix [N_TAPS];

    conv_pe uut (
        .clk       (clk),
        .rst_n     (rst_n),
        .wt_we     (wt_we),
        .wt_addr   (wt_addr),
        .wt_data   (wt_data),
        .start     (start),
        .pix_valid (pix_valid),
        .pix_data  (pix_data),
        .busy      (busy),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

    always #2 clk = ~clk;

    // ========================================================================
    // monitor sampling at the rising edge
    // ========================================================================
    always @(posedge clk) begin
        act_t expected;
        if (rst_n) begin
            if (!seen_start) begin
                assert (!busy && !out_valid) else begin
                    $display("[FAIL] %0t: busy or out_valid high before any start", $time);
                    fail_cnt++;
                end
            end
            if (start) seen_start = 1'b1;
            assert (out_valid == last_hist[2]) else begin
                $display("[FAIL] %0t: out_valid=%0b, expected %0b (2 cycles after last pixel)",
                         $time, out_valid, last_hist[2]);
                fail_cnt++;
            end
            if (out_valid) begin
                assert (busy) else begin
                    $display("[FAIL] %0t: busy low while out_valid high", $time);
                    fail_cnt++;
                end
                if (exp_q.size() == 0) begin
                    $display("result %0d arrived at %0t with nothing expected", out_data, $time);
                    other_cnt++;
                end else begin
                    expected = exp_q.pop_front();
                    assert (out_data == expected) else begin
                        $display("[FAIL] %0t: out_data=%0d, expected %0d",
                                 $time, out_data, expected);
                        fail_cnt++;
                    end
                end
            end
            if (prev_ov && !out_valid) begin
                assert (!busy) else begin
                    $display("[FAIL] %0t: busy still high after out_valid fell", $time);
                    fail_cnt++;
                end
            end
            prev_ov   = out_valid;
            last_hist = {last_hist[1:0], pix_valid && pix_last};
        end
    end

    initial begin
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout, run exceeded %0d cycles", MAX_CYCLES);
        $display("** FAIL **");
        $finish;
    end

    // ========================================================================
    // stimulus tasks driving 1 unit after the edge
    // ========================================================================
    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic write_kernel(input wgt_t mask, input wgt_t fill);
        for (int i = 0; i < N_TAPS; i++) begin
            kern[i] = (wgt_t'($random(seed)) & mask) | fill;
            wt_we   = 1'b1;
            wt_addr = tap_t'(i);
            wt_data = kern[i];
            step();
        end
        wt_addr = tap_t'(N_TAPS + ({$random(seed)} % 7));   // out of range address
        wt_data = wgt_t'($random(seed));
        step();
        wt_we = 1'b0;
    endtask

    task automatic fill_pixels(input act_t mask, input act_t fill);
        for (int i = 0; i < N_TAPS; i++) begin
            pix[i] = (act_t'($random(seed)) & mask) | fill;
        end
    endtask

    task automatic offer_idle_pixels(input int n);
        for (int i = 0; i < n; i++) begin
            pix_valid = 1'b1;
            pix_data  = act_t'($random(seed));
            step();
        end
        pix_valid = 1'b0;
    endtask

    task automatic feed_window(input bit gappy, input bit disturb);
        int gaps;
        int waited;
        gaps  = 0;
        start = 1'b1;
        step();
        start = 1'b0;
        for (int i = 0; i < N_TAPS; i++) begin
            if (gappy && gaps < MAX_GAPS && ($random(seed) & 3) == 0) begin
                pix_valid = 1'b0;
                pix_data  = act_t'($random(seed));   // junk on a gap
                step();
                gaps++;
            end
            pix_valid = 1'b1;
            pix_data  = pix[i];
            pix_last  = (i == N_TAPS - 1);
            if (disturb) begin
                start   = (i == 10);   // second start while busy
                wt_we   = 1'b1;
                wt_addr = tap_t'({$random(seed)} % N_TAPS);
                wt_data = wgt_t'($random(seed));
            end
            step();
        end
        pix_valid = 1'b0;
        pix_last  = 1'b0;
        start     = 1'b0;
        wt_we     = 1'b0;
        waited    = 0;
        while (busy && waited < WIN_CYC) begin
            step();
            waited++;
        end
        if (busy) begin
            $display("window did not finish within %0d cycles at %0t", WIN_CYC, $time);
            other_cnt++;
        end
    endtask

    task automatic model_window(input act_t mask, input bit gappy, input bit disturb);
        fill_pixels(mask, 8'h00);
        exp_q.push_back(window_result(kern, pix));
        feed_window(gappy, disturb);
    endtask

    // ========================================================================
    // test sequence
    // ========================================================================
    initial begin
        seed       = 21182;
        fail_cnt   = 0;
        other_cnt  = 0;
        seen_start = 1'b0;
        prev_ov    = 1'b0;
        last_hist  = 3'b000;
        clk        = 1'b0;
        rst_n      = 1'b0;
        wt_we      = 1'b0;
        wt_addr    = '0;
        wt_data    = '0;
        start      = 1'b0;
        pix_valid  = 1'b0;
        pix_data   = '0;
        pix_last   = 1'b0;
        repeat (RST_CYC) @(posedge clk);
        #1;
        rst_n = 1'b1;
        offer_idle_pixels(N_IDLE);

        write_kernel(8'hff, 8'h00);
        repeat (3) model_window(8'h1f, 1'b0, 1'b0);   // small pixels keep most sums low
        repeat (3) model_window(8'h1f, 1'b1, 1'b0);

        write_kernel(8'h1f, 8'h00);   // only compressed rows active
        model_window(8'hff, 1'b0, 1'b0);
        model_window(8'hff, 1'b1, 1'b1);
        offer_idle_pixels(4);
        model_window(8'hff, 1'b0, 1'b0);   // kernel must be unchanged

        write_kernel(8'h00, 8'hff);
        fill_pixels(8'h00, 8'hff);
        exp_q.push_back(8'hff);
        feed_window(1'b0, 1'b0);

        write_kernel(8'h00, 8'h00);
        fill_pixels(8'hff, 8'h00);
        exp_q.push_back(8'h00);
        feed_window(1'b1, 1'b0);

        repeat (4) step();
        if (exp_q.size() != 0) begin
            $display("%0d expected results never arrived", exp_q.size());
            other_cnt++;
        end
        $display("errors: %0d failed assertions, %0d other failures", fail_cnt, other_cnt);
        if (fail_cnt == 0 && other_cnt == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+tests
verilog/lenet_pkg.sv
verilog/approx_mul.sv
verilog/tap_counter.sv
verilog/conv_fsm.sv
verilog/weight_store.sv
verilog/mac_accum.sv
verilog/conv_pe.sv
tests/tb_conv_pe.sv

// ==== run.sh ====
#!/bin/sh
verilator --binary --timing --assert --top-module tb_conv_pe -f list.f -o sim_tb || exit 1
out=$(./obj_dir/sim_tb)
echo "$out"
echo "$out" | grep -qF "** PASS **" && echo "run passed" || { echo "run failed"; exit 1; }
